// ==== core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // OP_NOP sits at zero so a cleared slot decodes as a bubble
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_ADDIU,
        OP_ORI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_J
    } op_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        op_t       op;
        word_t     srca;
        word_t     srcb;
        word_t     imm;
        reg_addr_t rdst;
        logic      regwrite;
        logic      memread;
        logic      memwrite;
    } decoded_t;

    localparam word_t reset_vector = 32'hbfc0_0000;

    // kseg0 and kseg1 map straight onto the low 512 MB
    function automatic word_t translate_addr(input word_t vaddr);
        if (vaddr[31:30] == 2'b10) begin
            return {3'b000, vaddr[28:0]};
        end
        return vaddr;
    endfunction

endpackage

// ==== issue_if.sv ====
interface issue_if;

    core_pkg::decoded_t  op_data;
    logic                stall_x;

    // execute stage result, fed back for forwarding
    core_pkg::word_t     result_x;
    core_pkg::reg_addr_t rdst_x;
    logic                regwrite_x;

    modport decode (
        output op_data,
        input  stall_x,
        input  result_x,
        input  rdst_x,
        input  regwrite_x
    );

    modport execute (
        input  op_data,
        input  stall_x,
        output result_x,
        output rdst_x,
        output regwrite_x
    );

endinterface

// ==== regfile.sv ====
module regfile (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::reg_addr_t ra1,
    input  core_pkg::reg_addr_t ra2,
    output core_pkg::word_t     rd1,
    output core_pkg::word_t     rd2,
    input  logic                wvalid,
    input  core_pkg::reg_addr_t wa,
    input  core_pkg::word_t     wd
);

    core_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wvalid && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // $0 reads as zero whatever was written
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// ==== fetch_unit.sv ====
module fetch_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall_f,
    input  logic            redirect,
    input  core_pkg::word_t redirect_pc,
    output logic            ireq_valid,
    output core_pkg::word_t ireq_addr,
    input  logic            iresp_addr_ok,
    input  logic            iresp_data_ok,
    input  core_pkg::word_t iresp_data,
    output core_pkg::word_t instr,
    output core_pkg::word_t instr_pc,
    output logic            instr_valid,
    output logic            fetch_wait
);

    logic            req;
    logic            busy;
    logic            discard;
    core_pkg::word_t pc;
    core_pkg::word_t req_pc;
    logic            buf_valid;
    core_pkg::word_t buf_word;
    core_pkg::word_t buf_pc;
    logic            arrive;
    logic            fresh;
    logic            take;
    logic            launch;

    assign arrive = busy && iresp_data_ok;
    assign fresh  = arrive && !discard;

    // buffered word is always older than anything on the bus
    assign instr_valid = buf_valid || fresh;
    assign instr       = buf_valid ? buf_word : iresp_data;
    assign instr_pc    = buf_valid ? buf_pc : req_pc;
    assign fetch_wait  = !instr_valid;

    assign take   = instr_valid && !stall_f;
    assign launch = !req && (!busy || arrive) && !redirect && (!instr_valid || take);

    assign ireq_valid = req;
    assign ireq_addr  = core_pkg::translate_addr(req_pc);

    always_ff @(posedge clk) begin
        if (reset) begin
            req       <= 1'b0;
            busy      <= 1'b0;
            discard   <= 1'b0;
            buf_valid <= 1'b0;
            pc        <= core_pkg::reset_vector;
        end else begin
            if (req && iresp_addr_ok) begin
                req  <= 1'b0;
                busy <= 1'b1;
            end else if (launch) begin
                req    <= 1'b1;
                req_pc <= pc;
                pc     <= pc + 32'd4;
            end
            if (arrive) begin
                busy <= 1'b0;
            end

            // a request already on the bus still completes, its word is dropped
            if (redirect) begin
                pc      <= redirect_pc;
                discard <= req || (busy && !iresp_data_ok);
            end else if (arrive) begin
                discard <= 1'b0;
            end

            if (redirect) begin
                buf_valid <= 1'b0;
            end else if (fresh && stall_f) begin
                buf_valid <= 1'b1;
                buf_word  <= iresp_data;
                buf_pc    <= req_pc;
            end else if (!stall_f) begin
                buf_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== hazard_unit.sv ====
module hazard_unit (
    input  logic fetch_wait,
    input  logic mem_wait,
    input  logic load_use,
    input  logic redirect,
    output logic stall_f,
    output logic stall_d,
    output logic flush_d,
    output logic stall_x
);

    // memory wait freezes everything up to execute
    assign stall_x = mem_wait;

    // fetched word stays put while decode cannot take it
    assign stall_f = mem_wait || load_use;

    // no word to decode also means a bubble
    assign stall_d = mem_wait || load_use || fetch_wait;

    // kill wrong-path work unless memory holds the pipe
    assign flush_d = redirect && !mem_wait;

endmodule

// ==== mem_unit.sv ====
module mem_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            mem_req,
    input  core_pkg::word_t mem_addr,
    input  core_pkg::word_t mem_wdata,
    input  logic            mem_write,
    output logic            dreq_valid,
    output core_pkg::word_t dreq_addr,
    output logic            dreq_write,
    output core_pkg::word_t dreq_wdata,
    input  logic            dresp_addr_ok,
    input  logic            dresp_data_ok,
    input  core_pkg::word_t dresp_rdata,
    output core_pkg::word_t mem_rdata,
    output logic            mem_done,
    output logic            mem_wait
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_REQUEST,
        M_AWAIT
    } mem_state_t;

    mem_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= M_IDLE;
        end else begin
            case (state)
                M_IDLE: if (mem_req) state <= M_REQUEST;
                M_REQUEST: if (dresp_addr_ok) state <= M_AWAIT;
                M_AWAIT: if (dresp_data_ok) state <= M_IDLE;
                default: state <= M_IDLE;
            endcase
        end
    end

    // address and data are stable, execute holds the op until done
    assign dreq_valid = state == M_REQUEST;
    assign dreq_addr  = core_pkg::translate_addr(mem_addr);
    assign dreq_write = mem_write;
    assign dreq_wdata = mem_wdata;

    // stores finish on data_ok as well
    assign mem_done  = state == M_AWAIT && dresp_data_ok;
    assign mem_rdata = dresp_rdata;
    assign mem_wait  = mem_req && !mem_done;

endmodule

// ==== decode_unit.sv ====
module decode_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall_d,
    input  logic                flush_d,
    input  core_pkg::word_t     instr,
    input  core_pkg::word_t     instr_pc,
    input  logic                instr_valid,
    input  logic                wb_valid,
    input  core_pkg::reg_addr_t wb_addr,
    input  core_pkg::word_t     wb_data,
    output logic                load_use,
    issue_if.decode             issue
);

    core_pkg::reg_addr_t rs;
    core_pkg::reg_addr_t rt;
    core_pkg::word_t     rd1;
    core_pkg::word_t     rd2;
    core_pkg::word_t     srca;
    core_pkg::word_t     srcb;
    core_pkg::decoded_t  dec;

    assign rs = instr[25:21];
    assign rt = instr[20:16];

    regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .ra1    (rs),
        .ra2    (rt),
        .rd1    (rd1),
        .rd2    (rd2),
        .wvalid (wb_valid),
        .wa     (wb_addr),
        .wd     (wb_data)
    );

    // newest producer wins, regwrite is never set for $0
    always_comb begin
        srca = rd1;
        srcb = rd2;
        if (issue.regwrite_x && issue.rdst_x == rs) begin
            srca = issue.result_x;
        end else if (wb_valid && wb_addr == rs) begin
            srca = wb_data;
        end
        if (issue.regwrite_x && issue.rdst_x == rt) begin
            srcb = issue.result_x;
        end else if (wb_valid && wb_addr == rt) begin
            srcb = wb_data;
        end
    end

    // load in execute has no data yet, rt compared even when unused
    assign load_use = instr_valid && issue.op_data.valid && issue.op_data.memread
                      && (issue.rdst_x == rs || issue.rdst_x == rt);

    always_comb begin
        dec       = '0;
        dec.valid = instr_valid;
        dec.pc    = instr_pc;
        dec.srca  = srca;
        dec.srcb  = srcb;
        dec.imm   = {{16{instr[15]}}, instr[15:0]};
        dec.rdst  = rt;
        case (instr[31:26])
            6'h00: begin
                dec.rdst = instr[15:11];
                dec.imm  = {27'd0, instr[10:6]};
                case (instr[5:0])
                    6'h21: dec.op = core_pkg::OP_ADDU;
                    6'h23: dec.op = core_pkg::OP_SUBU;
                    6'h24: dec.op = core_pkg::OP_AND;
                    6'h25: dec.op = core_pkg::OP_OR;
                    6'h26: dec.op = core_pkg::OP_XOR;
                    6'h2a: dec.op = core_pkg::OP_SLT;
                    6'h00: dec.op = core_pkg::OP_SLL;
                    default: dec.op = core_pkg::OP_NOP;
                endcase
            end
            6'h09: dec.op = core_pkg::OP_ADDIU;
            6'h0d: begin
                dec.op  = core_pkg::OP_ORI;
                dec.imm = {16'd0, instr[15:0]};
            end
            6'h0f: begin
                dec.op  = core_pkg::OP_LUI;
                dec.imm = {instr[15:0], 16'd0};
            end
            6'h23: begin
                dec.op      = core_pkg::OP_LW;
                dec.memread = 1'b1;
            end
            6'h2b: begin
                dec.op       = core_pkg::OP_SW;
                dec.memwrite = 1'b1;
            end
            6'h04, 6'h05: begin
                dec.op  = instr[26] ? core_pkg::OP_BNE : core_pkg::OP_BEQ;
                dec.imm = {{14{instr[15]}}, instr[15:0], 2'b00};
            end
            6'h02: begin
                dec.op  = core_pkg::OP_J;
                dec.imm = {4'd0, instr[25:0], 2'b00};
            end
            default: dec.op = core_pkg::OP_NOP;
        endcase
        dec.regwrite = dec.rdst != 5'd0 && !(dec.op inside {core_pkg::OP_NOP,
            core_pkg::OP_SW, core_pkg::OP_BEQ, core_pkg::OP_BNE, core_pkg::OP_J});
    end

    // decode to execute register, bubble when decode cannot hand over
    always_ff @(posedge clk) begin
        if (reset) begin
            issue.op_data <= '0;
        end else if (!issue.stall_x) begin
            if (flush_d || stall_d) begin
                issue.op_data <= '0;
            end else begin
                issue.op_data <= dec;
            end
        end
    end

endmodule

// ==== execute_unit.sv ====
module execute_unit (
    input  logic                clk,
    input  logic                reset,
    issue_if.execute            issue,
    output logic                redirect,
    output core_pkg::word_t     redirect_pc,
    output logic                dreq_valid,
    output core_pkg::word_t     dreq_addr,
    output logic                dreq_write,
    output core_pkg::word_t     dreq_wdata,
    input  logic                dresp_addr_ok,
    input  logic                dresp_data_ok,
    input  core_pkg::word_t     dresp_rdata,
    output logic                mem_wait,
    output logic                wb_valid,
    output core_pkg::reg_addr_t wb_addr,
    output core_pkg::word_t     wb_data
);

    core_pkg::decoded_t d;
    core_pkg::word_t    alu;
    core_pkg::word_t    result;
    core_pkg::word_t    pc_plus4;
    core_pkg::word_t    mem_rdata;
    logic               mem_req;
    logic               mem_done;

    assign d = issue.op_data;

    always_comb begin
        case (d.op)
            core_pkg::OP_ADDU:  alu = d.srca + d.srcb;
            core_pkg::OP_SUBU:  alu = d.srca - d.srcb;
            core_pkg::OP_AND:   alu = d.srca & d.srcb;
            core_pkg::OP_OR:    alu = d.srca | d.srcb;
            core_pkg::OP_XOR:   alu = d.srca ^ d.srcb;
            core_pkg::OP_SLT:   alu = {31'd0, $signed(d.srca) < $signed(d.srcb)};
            core_pkg::OP_SLL:   alu = d.srcb << d.imm[4:0];
            core_pkg::OP_ORI:   alu = d.srca | d.imm;
            core_pkg::OP_LUI:   alu = d.imm;
            // ADDIU, LW and SW share the adder
            core_pkg::OP_ADDIU,
            core_pkg::OP_LW,
            core_pkg::OP_SW:    alu = d.srca + d.imm;
            default:            alu = '0;
        endcase
    end

    // branch offsets count from the next instruction as in MIPS
    assign pc_plus4 = d.pc + 32'd4;
    assign redirect = d.valid && ((d.op == core_pkg::OP_BEQ && d.srca == d.srcb)
                      || (d.op == core_pkg::OP_BNE && d.srca != d.srcb)
                      || d.op == core_pkg::OP_J);
    assign redirect_pc = (d.op == core_pkg::OP_J) ? {pc_plus4[31:28], d.imm[27:0]}
                                                  : pc_plus4 + d.imm;

    assign mem_req = d.valid && (d.memread || d.memwrite);

    mem_unit u_mem (
        .clk           (clk),
        .reset         (reset),
        .mem_req       (mem_req),
        .mem_addr      (alu),
        .mem_wdata     (d.srcb),
        .mem_write     (d.memwrite),
        .dreq_valid    (dreq_valid),
        .dreq_addr     (dreq_addr),
        .dreq_write    (dreq_write),
        .dreq_wdata    (dreq_wdata),
        .dresp_addr_ok (dresp_addr_ok),
        .dresp_data_ok (dresp_data_ok),
        .dresp_rdata   (dresp_rdata),
        .mem_rdata     (mem_rdata),
        .mem_done      (mem_done),
        .mem_wait      (mem_wait)
    );

    assign result           = d.memread ? mem_rdata : alu;
    assign issue.result_x   = result;
    assign issue.rdst_x     = d.rdst;
    assign issue.regwrite_x = d.valid && d.regwrite;

    // a waiting load writes nothing back until its data is in
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= d.valid && d.regwrite && !issue.stall_x;
        end
        wb_addr <= d.rdst;
        wb_data <= result;
    end

endmodule

// ==== core_top.sv ====
module core_top (
    input  logic        clk,
    input  logic        reset,
    output logic        ireq_valid,
    output logic [31:0] ireq_addr,
    input  logic        iresp_addr_ok,
    input  logic        iresp_data_ok,
    input  logic [31:0] iresp_data,
    output logic        dreq_valid,
    output logic [31:0] dreq_addr,
    output logic        dreq_write,
    output logic [31:0] dreq_wdata,
    input  logic        dresp_addr_ok,
    input  logic        dresp_data_ok,
    input  logic [31:0] dresp_rdata
);

    core_pkg::word_t     instr;
    core_pkg::word_t     instr_pc;
    logic                instr_valid;
    logic                fetch_wait;
    logic                load_use;
    logic                mem_wait;
    logic                stall_f;
    logic                stall_d;
    logic                flush_d;
    logic                redirect;
    core_pkg::word_t     redirect_pc;
    logic                wb_valid;
    core_pkg::reg_addr_t wb_addr;
    core_pkg::word_t     wb_data;

    issue_if issue ();

    fetch_unit u_fetch (
        .clk           (clk),
        .reset         (reset),
        .stall_f       (stall_f),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (ireq_addr),
        .iresp_addr_ok (iresp_addr_ok),
        .iresp_data_ok (iresp_data_ok),
        .iresp_data    (iresp_data),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .instr_valid   (instr_valid),
        .fetch_wait    (fetch_wait)
    );

    decode_unit u_decode (
        .clk         (clk),
        .reset       (reset),
        .stall_d     (stall_d),
        .flush_d     (flush_d),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .load_use    (load_use),
        .issue       (issue.decode)
    );

    hazard_unit u_hazard (
        .fetch_wait (fetch_wait),
        .mem_wait   (mem_wait),
        .load_use   (load_use),
        .redirect   (redirect),
        .stall_f    (stall_f),
        .stall_d    (stall_d),
        .flush_d    (flush_d),
        .stall_x    (issue.stall_x)
    );

    execute_unit u_execute (
        .clk           (clk),
        .reset         (reset),
        .issue         (issue.execute),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .dreq_valid    (dreq_valid),
        .dreq_addr     (dreq_addr),
        .dreq_write    (dreq_write),
        .dreq_wdata    (dreq_wdata),
        .dresp_addr_ok (dresp_addr_ok),
        .dresp_data_ok (dresp_data_ok),
        .dresp_rdata   (dresp_rdata),
        .mem_wait      (mem_wait),
        .wb_valid      (wb_valid),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data)
    );

endmodule

// ==== core_tb.sv ====
module core_tb;

    logic        clk;
    logic        reset;
    logic        ireq_valid;
    logic [31:0] ireq_addr;
    logic        iresp_addr_ok;
    logic        iresp_data_ok;
    logic [31:0] iresp_data;
    logic        dreq_valid;
    logic [31:0] dreq_addr;
    logic        dreq_write;
    logic [31:0] dreq_wdata;
    logic        dresp_addr_ok;
    logic        dresp_data_ok;
    logic [31:0] dresp_rdata;

    // memories keyed by physical address
    logic [31:0] imem [logic [31:0]];
    logic [31:0] dmem [logic [31:0]];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    // parsed test file
    byte         kinds [$];
    logic [31:0] addrs [$];
    logic [31:0] words [$];
    string       names [$];
    int          starts [$];

    string       cur_name;
    int          store_count;
    bit          cur_has_data;
    bit          random_delays;
    int          mismatch_errors;
    int          other_errors;
    int unsigned lcg_state;

    // bus responder state
    int          ia_wait;
    int          id_wait;
    int          da_wait;
    int          dd_wait;
    bit          ia_count;
    bit          da_count;
    bit          i_pend;
    bit          d_pend;
    bit          d_write;
    logic [31:0] i_addr;
    logic [31:0] d_addr;

    core_top DUT (
        .clk           (clk),
        .reset         (reset),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (ireq_addr),
        .iresp_addr_ok (iresp_addr_ok),
        .iresp_data_ok (iresp_data_ok),
        .iresp_data    (iresp_data),
        .dreq_valid    (dreq_valid),
        .dreq_addr     (dreq_addr),
        .dreq_write    (dreq_write),
        .dreq_wdata    (dreq_wdata),
        .dresp_addr_ok (dresp_addr_ok),
        .dresp_data_ok (dresp_data_ok),
        .dresp_rdata   (dresp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 0 to 3 cycles in random mode, no delay otherwise
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        if (!random_delays) begin
            return 0;
        end
        return int'(lcg_state[17:16]);
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] a, input bit data_side);
        if (data_side) begin
            return dmem.exists(a) ? dmem[a] : 32'd0;
        end
        return imem.exists(a) ? imem[a] : 32'd0;
    endfunction

    task automatic check_store(input logic [31:0] a, input logic [31:0] w);
        if (store_count >= exp_addr.size()) begin
            $display("test %s made an unexpected store of %h to %h", cur_name, w, a);
            other_errors++;
        end else if (a != exp_addr[store_count] || w != exp_data[store_count]) begin
            $display("[ERROR] test %s store %0d expected %h:%h actual %h:%h", cur_name,
                     store_count, exp_addr[store_count], exp_data[store_count], a, w);
            mismatch_errors++;
        end
        store_count++;
    endtask

    // both bus responders, driven 2 units after the edge
    always @(posedge clk) begin
        #2;
        iresp_addr_ok = 1'b0;
        iresp_data_ok = 1'b0;
        dresp_addr_ok = 1'b0;
        dresp_data_ok = 1'b0;
        if (reset) begin
            ia_count = 1'b0;
            da_count = 1'b0;
            i_pend   = 1'b0;
            d_pend   = 1'b0;
        end else begin
            if (i_pend) begin
                if (id_wait == 0) begin
                    iresp_data_ok = 1'b1;
                    iresp_data    = read_word(i_addr, 1'b0);
                    i_pend        = 1'b0;
                end else begin
                    id_wait--;
                end
            end
            if (ireq_valid && !i_pend) begin
                if (!ia_count) begin
                    ia_wait  = next_delay();
                    ia_count = 1'b1;
                end
                if (ia_wait == 0) begin
                    iresp_addr_ok = 1'b1;
                    i_addr        = ireq_addr;
                    i_pend        = 1'b1;
                    ia_count      = 1'b0;
                    id_wait       = next_delay();
                end else begin
                    ia_wait--;
                end
            end

            if (d_pend) begin
                if (dd_wait == 0) begin
                    dresp_data_ok = 1'b1;
                    dresp_rdata   = d_write ? 32'd0 : read_word(d_addr, 1'b1);
                    d_pend        = 1'b0;
                end else begin
                    dd_wait--;
                end
            end
            if (dreq_valid && !d_pend) begin
                if (!da_count) begin
                    da_wait  = next_delay();
                    da_count = 1'b1;
                end
                if (da_wait == 0) begin
                    dresp_addr_ok = 1'b1;
                    d_addr        = dreq_addr;
                    d_write       = dreq_write;
                    d_pend        = 1'b1;
                    da_count      = 1'b0;
                    dd_wait       = next_delay();
                    if (dreq_write) begin
                        check_store(dreq_addr, dreq_wdata);
                        dmem[dreq_addr] = dreq_wdata;
                    end else if (!cur_has_data) begin
                        $display("test %s issued a load with no preset data", cur_name);
                        other_errors++;
                    end
                end else begin
                    da_wait--;
                end
            end
        end
    end

    task automatic read_tests();
        int          fd;
        int          n;
        string       line;
        string       nm;
        logic [31:0] a;
        logic [31:0] w;
        fd = $fopen("core_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open core_tests.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] == "T") begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%s", nm);
                    names.push_back(nm);
                    starts.push_back(kinds.size());
                end else if (n > 1 && line[0] inside {"I", "D", "E"}) begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, w);
                    kinds.push_back(line[0]);
                    addrs.push_back(a);
                    words.push_back(w);
                end
            end
            $fclose(fd);
            starts.push_back(kinds.size());
        end
    endtask

    task automatic run_test(input int t);
        int timeout;
        cur_name     = names[t];
        cur_has_data = 1'b0;
        store_count  = 0;
        imem.delete();
        dmem.delete();
        exp_addr.delete();
        exp_data.delete();
        for (int i = starts[t]; i < starts[t + 1]; i++) begin
            if (kinds[i] == "I") begin
                imem[addrs[i]] = words[i];
            end else if (kinds[i] == "D") begin
                dmem[addrs[i]] = words[i];
                cur_has_data   = 1'b1;
            end else begin
                exp_addr.push_back(addrs[i]);
                exp_data.push_back(words[i]);
            end
        end

        reset = 1'b1;
        repeat (8) begin
            @(posedge clk);
            #1;
        end
        if (ireq_valid || dreq_valid) begin
            $display("test %s saw a bus request during reset", cur_name);
            other_errors++;
        end
        reset = 1'b0;

        timeout = 0;
        while (!ireq_valid && timeout < 100) begin
            @(posedge clk);
            #1;
            timeout++;
        end
        if (!ireq_valid) begin
            $display("test %s never issued an instruction request", cur_name);
            other_errors++;
        end else if (ireq_addr != 32'h1fc0_0000) begin
            $display("[ERROR] test %s first fetch expected %h actual %h", cur_name,
                     32'h1fc0_0000, ireq_addr);
            mismatch_errors++;
        end

        timeout = 0;
        while (store_count < exp_addr.size() && timeout < 3000) begin
            @(posedge clk);
            #1;
            timeout++;
        end
        if (store_count < exp_addr.size()) begin
            $display("test %s did not finish its stores, %0d of %0d seen", cur_name,
                     store_count, exp_addr.size());
            other_errors++;
        end

        // idle time so that stray stores show up
        repeat (60) @(posedge clk);
        #1;
    endtask

    initial begin
        reset           = 1'b1;
        iresp_addr_ok   = 1'b0;
        iresp_data_ok   = 1'b0;
        iresp_data      = 32'd0;
        dresp_addr_ok   = 1'b0;
        dresp_data_ok   = 1'b0;
        dresp_rdata     = 32'd0;
        lcg_state       = 32'd85672;
        random_delays   = 1'b0;
        mismatch_errors = 0;
        other_errors    = 0;
        cur_name        = "none";

        read_tests();
        // first pass with zero bus delay, second with random delays
        for (int p = 0; p < 2; p++) begin
            random_delays = (p == 1);
            for (int t = 0; t < names.size(); t++) begin
                run_test(t);
            end
        end

        $display("errors: %0d store mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0 && names.size() > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== core_tests.txt ====
# T name, then I addr word (program), D addr word (preset data), E addr word (expected store)
# all addresses physical, all values hex
T alu
I 1fc00000 3c01a000
I 1fc00004 24020005
I 1fc00008 2403fffd
I 1fc0000c 00432021
I 1fc00010 ac240000
I 1fc00014 00432823
I 1fc00018 ac250004
I 1fc0001c 0062302a
I 1fc00020 ac260008
I 1fc00024 3407f0f0
I 1fc00028 00e34026
I 1fc0002c 00e34824
I 1fc00030 00475025
I 1fc00034 00025900
I 1fc00038 ac28000c
I 1fc0003c ac290010
I 1fc00040 ac2a0014
I 1fc00044 ac2b0018
I 1fc00048 0bf00012
E 00000000 00000002
E 00000004 00000008
E 00000008 00000001
E 0000000c ffff0f0d
E 00000010 0000f0f0
E 00000014 0000f0f5
E 00000018 00000050
T load_use
I 1fc00000 3c01a000
I 1fc00004 8c220100
I 1fc00008 00421821
I 1fc0000c ac230000
I 1fc00010 24640001
I 1fc00014 00822823
I 1fc00018 ac250004
I 1fc0001c ac240104
I 1fc00020 8c260104
I 1fc00024 ac260008
I 1fc00028 0bf0000a
D 00000100 0000002a
E 00000000 00000054
E 00000004 0000002b
E 00000104 00000055
E 00000008 00000055
T branch
I 1fc00000 3c01a000
I 1fc00004 24020007
I 1fc00008 24030007
I 1fc0000c 10430002
I 1fc00010 ac220040
I 1fc00014 ac230044
I 1fc00018 14430002
I 1fc0001c ac220000
I 1fc00020 24040009
I 1fc00024 14440002
I 1fc00028 ac240048
I 1fc0002c ac24004c
I 1fc00030 10440001
I 1fc00034 ac240004
I 1fc00038 0bf00011
I 1fc0003c ac220050
I 1fc00040 ac220054
I 1fc00044 ac230008
I 1fc00048 0bf00012
E 00000000 00000007
E 00000004 00000009
E 00000008 00000007

// ==== verilog.f ====
core_pkg.sv
issue_if.sv
regfile.sv
fetch_unit.sv
hazard_unit.sv
mem_unit.sv
decode_unit.sv
execute_unit.sv
core_top.sv
core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell cat verilog.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) verilog.f
	$(VERILATOR) $(VFLAGS) -f verilog.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM) core_tests.txt
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
